//--- common/post_video_params.svh
`ifndef POST_VIDEO_PARAMS_SVH
`define POST_VIDEO_PARAMS_SVH

// default raster is XGA 1024x768 at 65 MHz
// horizontal geometry in pixels
`define POST_H_ACTIVE    1024
`define POST_H_FP        24
`define POST_H_SYNC      136
`define POST_H_BP        160

// vertical geometry in lines
`define POST_V_ACTIVE    768
`define POST_V_FP        3
`define POST_V_SYNC      6
`define POST_V_BP        29

// sync delay taps
`define POST_IN_DELAY    5      // early tap, external post block
`define POST_OUT_DELAY   30     // extra depth up to the display encoder
`define POST_TOTAL_DELAY (`POST_IN_DELAY + `POST_OUT_DELAY)

// data widths
`define POST_PIX_W       16     // rgb565
`define POST_COLOR_W     8
`define POST_CNT_W       11     // enough for 1344 pixels per line

`endif

//--- common/post_video_pkg.sv
`default_nettype none

`include "post_video_params.svh"

package post_video_pkg;

    typedef logic [`POST_PIX_W-1:0]   pixel_t;    // rgb565
    typedef logic [`POST_COLOR_W-1:0] color_t;
    typedef logic [`POST_CNT_W-1:0]   count_t;    // pixel or line position

    // hs and vs are active low
    typedef struct packed
    {
        logic hs;
        logic vs;
        logic de;
    } video_sync_t;

    typedef struct packed
    {
        color_t r;
        color_t g;
        color_t b;
    } rgb_t;

    // blanking value of the sync bundle
    localparam video_sync_t SYNC_IDLE = '{hs: 1'b1, vs: 1'b1, de: 1'b0};

    typedef enum logic [1:0]
    {
        WAIT_FINISH,
        WAIT_VS_LOW,
        WAIT_VS_HIGH,
        WAIT_VS_LOW_AGAIN
    } frame_gate_state_t;

endpackage

`default_nettype wire

//--- hdl/frame_gate_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module frame_gate_ctrl
(
    input  wire  o_post_clk,
    input  wire  rst_n,
    input  wire  i_finish,     // post block done with the last frame
    input  wire  i_vs,         // early post vs, active low
    output logic o_post_camvs
);

    post_video_pkg::frame_gate_state_t state;

    // camvs covers one whole vs period of the post stream
    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state        <= post_video_pkg::WAIT_FINISH;
            o_post_camvs <= 1'b0;
        end
        else
        begin
            case (state)
                post_video_pkg::WAIT_FINISH:
                begin
                    if (i_finish)
                        state <= post_video_pkg::WAIT_VS_LOW;
                end
                post_video_pkg::WAIT_VS_LOW:
                begin
                    if (!i_vs)
                    begin
                        state        <= post_video_pkg::WAIT_VS_HIGH;
                        o_post_camvs <= 1'b1;
                    end
                end
                post_video_pkg::WAIT_VS_HIGH:
                begin
                    if (i_vs)
                        state <= post_video_pkg::WAIT_VS_LOW_AGAIN;
                end
                post_video_pkg::WAIT_VS_LOW_AGAIN:
                begin
                    if (!i_vs)
                    begin
                        state        <= post_video_pkg::WAIT_FINISH;
                        o_post_camvs <= 1'b0;   // back to idle
                    end
                end
                default:
                begin
                    state        <= post_video_pkg::WAIT_FINISH;
                    o_post_camvs <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/pixel_stage.sv
`timescale 1ns/100ps
`default_nettype none

module pixel_stage
(
    input  wire                         o_post_clk,
    input  wire                         rst_n,

    input  wire                         i_fb_den,
    input  post_video_pkg::pixel_t      i_fb_data,

    input  post_video_pkg::video_sync_t i_late_sync,
    input  post_video_pkg::rgb_t        i_post_rgb,

    output post_video_pkg::pixel_t      o_post_data,
    output post_video_pkg::video_sync_t o_disp_sync,
    output post_video_pkg::rgb_t        o_disp_rgb
);

    // invalid buffer words go out as black
    assign o_post_data = i_fb_den ? i_fb_data : '0;

    // sync and color leave the same flop stage towards the encoder
    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_disp_sync <= post_video_pkg::SYNC_IDLE;
            o_disp_rgb  <= '0;
        end
        else
        begin
            o_disp_sync <= i_late_sync;
            o_disp_rgb  <= i_post_rgb;
        end
    end

endmodule

`default_nettype wire

//--- hdl/post_video_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "post_video_params.svh"

module post_video_top
#(
    parameter int H_ACTIVE = `POST_H_ACTIVE,
    parameter int H_FP     = `POST_H_FP,
    parameter int H_SYNC   = `POST_H_SYNC,
    parameter int H_BP     = `POST_H_BP,
    parameter int V_ACTIVE = `POST_V_ACTIVE,
    parameter int V_FP     = `POST_V_FP,
    parameter int V_SYNC   = `POST_V_SYNC,
    parameter int V_BP     = `POST_V_BP
)
(
    input  wire                        o_post_clk,
    input  wire                        rst_n,

    // frame handshake from the post block
    input  wire                        i_finish,

    // frame buffer read side
    input  wire                        i_fb_den,
    input  post_video_pkg::pixel_t     i_fb_data,

    // processed colors back from the post block
    input  post_video_pkg::rgb_t       i_post_rgb,

    // post stream
    output logic                       o_post_vs,
    output logic                       o_post_de,
    output post_video_pkg::pixel_t     o_post_data,
    output logic                       o_post_camvs,

    // display encoder bundle
    output post_video_pkg::video_sync_t o_disp_sync,
    output post_video_pkg::rgb_t       o_disp_rgb
);

    post_video_pkg::video_sync_t raw_sync;
    post_video_pkg::video_sync_t early_sync;
    post_video_pkg::video_sync_t late_sync;

    video_timing_gen
    #(
        .H_ACTIVE (H_ACTIVE),
        .H_FP     (H_FP),
        .H_SYNC   (H_SYNC),
        .H_BP     (H_BP),
        .V_ACTIVE (V_ACTIVE),
        .V_FP     (V_FP),
        .V_SYNC   (V_SYNC),
        .V_BP     (V_BP)
    )
    video_timing_gen_inst
    (
        .o_post_clk (o_post_clk),
        .rst_n      (rst_n),
        .o_sync     (raw_sync)
    );

    sync_delay_line sync_delay_line_inst
    (
        .o_post_clk   (o_post_clk),
        .rst_n        (rst_n),
        .i_sync       (raw_sync),
        .o_early_sync (early_sync),
        .o_late_sync  (late_sync)
    );

    assign o_post_vs = early_sync.vs;
    assign o_post_de = early_sync.de;   // early hs goes nowhere

    pixel_stage pixel_stage_inst
    (
        .o_post_clk  (o_post_clk),
        .rst_n       (rst_n),
        .i_fb_den    (i_fb_den),
        .i_fb_data   (i_fb_data),
        .i_late_sync (late_sync),
        .i_post_rgb  (i_post_rgb),
        .o_post_data (o_post_data),
        .o_disp_sync (o_disp_sync),
        .o_disp_rgb  (o_disp_rgb)
    );

    frame_gate_ctrl frame_gate_ctrl_inst
    (
        .o_post_clk   (o_post_clk),
        .rst_n        (rst_n),
        .i_finish     (i_finish),
        .i_vs         (early_sync.vs),
        .o_post_camvs (o_post_camvs)
    );

endmodule

`default_nettype wire

//--- testbench/post_video_model.svh
`ifndef POST_VIDEO_MODEL_SVH
`define POST_VIDEO_MODEL_SVH

int   mdl_h;
int   mdl_v;
int   gate_phase;      // 0 idle, 1 armed, 2 high in vs low, 3 high in vs high
logic exp_camvs;

post_video_pkg::video_sync_t sync_hist [$];   // newest raw sync at index 0

// hs and vs active low, order is active, porch, sync, porch
function automatic post_video_pkg::video_sync_t raster_sync(input int h, input int v);
    post_video_pkg::video_sync_t s;
    s.hs = !((h >= TB_H_ACTIVE + TB_H_FP) && (h < TB_H_ACTIVE + TB_H_FP + TB_H_SYNC));
    s.vs = !((v >= TB_V_ACTIVE + TB_V_FP) && (v < TB_V_ACTIVE + TB_V_FP + TB_V_SYNC));
    s.de = (h < TB_H_ACTIVE) && (v < TB_V_ACTIVE);
    return s;
endfunction

task automatic model_reset();
    post_video_pkg::video_sync_t idle;
    idle.hs = 1'b1;
    idle.vs = 1'b1;
    idle.de = 1'b0;
    mdl_h      = 0;
    mdl_v      = 0;
    gate_phase = 0;
    exp_camvs  = 1'b0;
    sync_hist.delete();
    repeat (`POST_TOTAL_DELAY + 2)
        sync_hist.push_back(idle);
endtask

// one rising edge with the inputs seen just before it
task automatic model_clock(input logic finish, input logic running);
    logic vs_now;
    if (running)
    begin
        vs_now = sync_hist[`POST_IN_DELAY].vs;   // what o_post_vs shows now
        case (gate_phase)
            0: if (finish) gate_phase = 1;
            1: if (!vs_now)
               begin
                   gate_phase = 2;
                   exp_camvs  = 1'b1;
               end
            2: if (vs_now) gate_phase = 3;
            default: if (!vs_now)
               begin
                   gate_phase = 0;
                   exp_camvs  = 1'b0;
               end
        endcase
        sync_hist.push_front(raster_sync(mdl_h, mdl_v));
        void'(sync_hist.pop_back());
        if (mdl_h == TB_H_TOTAL - 1)
        begin
            mdl_h = 0;
            mdl_v = (mdl_v == TB_V_TOTAL - 1) ? 0 : mdl_v + 1;
        end
        else
            mdl_h = mdl_h + 1;
    end
endtask

function automatic post_video_pkg::video_sync_t early_expected();
    return sync_hist[`POST_IN_DELAY];
endfunction

function automatic post_video_pkg::video_sync_t disp_expected();
    return sync_hist[`POST_TOTAL_DELAY + 1];   // plus the display register
endfunction

`endif

//--- testbench/post_video_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "post_video_params.svh"

module post_video_tb;

    localparam int TB_H_ACTIVE  = 16;
    localparam int TB_H_FP      = 2;
    localparam int TB_H_SYNC    = 3;
    localparam int TB_H_BP      = 3;
    localparam int TB_V_ACTIVE  = 8;
    localparam int TB_V_FP      = 1;
    localparam int TB_V_SYNC    = 2;
    localparam int TB_V_BP      = 2;
    localparam int TB_H_TOTAL   = TB_H_ACTIVE + TB_H_FP + TB_H_SYNC + TB_H_BP;
    localparam int TB_V_TOTAL   = TB_V_ACTIVE + TB_V_FP + TB_V_SYNC + TB_V_BP;
    localparam int FRAME_CYCLES = TB_H_TOTAL * TB_V_TOTAL;   // 312
    localparam int RESET_CYCLES = 10;
    localparam int N_ROWS       = 6;

    typedef struct packed
    {
        int wait_frames;
        int pulse_len;
        int observe_frames;
    } stim_row_t;

    logic                        o_post_clk;
    logic                        rst_n;
    logic                        i_finish;
    logic                        i_fb_den;
    post_video_pkg::pixel_t      i_fb_data;
    post_video_pkg::rgb_t        i_post_rgb;
    logic                        o_post_vs;
    logic                        o_post_de;
    post_video_pkg::pixel_t      o_post_data;
    logic                        o_post_camvs;
    post_video_pkg::video_sync_t o_disp_sync;
    post_video_pkg::rgb_t        o_disp_rgb;

    stim_row_t            stim_table [N_ROWS];
    logic [15:0]          lfsr_state;
    post_video_pkg::rgb_t exp_rgb;
    int                   cycle_cnt = 0;
    int                   cycle_limit = 0;
    int                   de_run;
    int                   line_cnt;
    int                   frames_seen;
    int                   camvs_rises;
    logic                 prev_de;
    logic                 prev_vs;
    logic                 prev_camvs;

    `include "post_video_model.svh"

    post_video_top
    #(
        .H_ACTIVE (TB_H_ACTIVE),
        .H_FP     (TB_H_FP),
        .H_SYNC   (TB_H_SYNC),
        .H_BP     (TB_H_BP),
        .V_ACTIVE (TB_V_ACTIVE),
        .V_FP     (TB_V_FP),
        .V_SYNC   (TB_V_SYNC),
        .V_BP     (TB_V_BP)
    )
    post_video_top_inst
    (
        .o_post_clk   (o_post_clk),
        .rst_n        (rst_n),
        .i_finish     (i_finish),
        .i_fb_den     (i_fb_den),
        .i_fb_data    (i_fb_data),
        .i_post_rgb   (i_post_rgb),
        .o_post_vs    (o_post_vs),
        .o_post_de    (o_post_de),
        .o_post_data  (o_post_data),
        .o_post_camvs (o_post_camvs),
        .o_disp_sync  (o_disp_sync),
        .o_disp_rgb   (o_disp_rgb)
    );

    initial
    begin
        o_post_clk = 1'b0;
        forever #5 o_post_clk = ~o_post_clk;
    end

    // galois lfsr stepped once per bit
    function automatic logic [31:0] draw_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 16'hB400) : (lfsr_state >> 1);
            val = {val[30:0], lfsr_state[0]};
        end
        return val;
    endfunction

    task automatic report_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        $display("[ERROR] %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        $display("TESTS FAILED");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic report_plain(input string what);
        $display("%s", what);
        $display("TESTS FAILED");
        $fatal(1, "stopped");
    endtask

    task automatic check_outputs();
        post_video_pkg::video_sync_t exp_early;
        post_video_pkg::video_sync_t exp_disp;
        exp_early = early_expected();
        exp_disp  = disp_expected();
        assert (o_post_vs === exp_early.vs) else report_value("o_post_vs", o_post_vs, exp_early.vs);
        assert (o_post_de === exp_early.de) else report_value("o_post_de", o_post_de, exp_early.de);
        assert (o_disp_sync === exp_disp) else report_value("o_disp_sync", o_disp_sync, exp_disp);
        assert (o_disp_rgb === exp_rgb) else report_value("o_disp_rgb", o_disp_rgb, exp_rgb);
        // valid words pass through, invalid ones must read as zero
        if (i_fb_den)
        begin
            assert (o_post_data === i_fb_data)
                else report_value("o_post_data", o_post_data, i_fb_data);
        end
        else
        begin
            assert (o_post_data === 16'h0000)
                else report_value("o_post_data", o_post_data, 0);
        end
        assert (o_post_camvs === exp_camvs)
            else report_value("o_post_camvs", o_post_camvs, exp_camvs);
        // line and frame shape on the early tap
        if (o_post_de)
            de_run = de_run + 1;
        else if (prev_de)
        begin
            assert (de_run == TB_H_ACTIVE) else report_value("o_post_de run", de_run, TB_H_ACTIVE);
            line_cnt = line_cnt + 1;
            de_run   = 0;
        end
        if (prev_vs && !o_post_vs)
        begin
            assert (line_cnt == TB_V_ACTIVE)
                else report_value("o_post_de lines", line_cnt, TB_V_ACTIVE);
            line_cnt    = 0;
            frames_seen = frames_seen + 1;
        end
        if (o_post_camvs && !prev_camvs)
            camvs_rises = camvs_rises + 1;
        prev_de    = o_post_de;
        prev_vs    = o_post_vs;
        prev_camvs = o_post_camvs;
    endtask

    task automatic check_reset_outputs();
        assert (o_post_vs === 1'b1) else report_value("o_post_vs", o_post_vs, 1);
        assert (o_post_de === 1'b0) else report_value("o_post_de", o_post_de, 0);
        assert (o_post_camvs === 1'b0) else report_value("o_post_camvs", o_post_camvs, 0);
        assert (o_post_data === '0) else report_value("o_post_data", o_post_data, 0);
        assert (o_disp_sync === 3'b110) else report_value("o_disp_sync", o_disp_sync, 3'b110);
    endtask

    // one clock with the model first, new inputs next and the check at the falling edge
    task automatic step(input logic stim_on, input logic pulse_on, input logic release_rst);
        logic fin_val;
        logic den_val;
        @(posedge o_post_clk);
        model_clock(i_finish, rst_n);
        exp_rgb = rst_n ? i_post_rgb : '0;
        if (pulse_on)
            fin_val = 1'b1;
        else if (gate_phase >= 2)
            fin_val = (draw_bits(3) == 0);   // stray finish while camvs is high
        else
            fin_val = 1'b0;
        den_val = stim_on ? (draw_bits(1) != 0) : 1'b0;
        i_finish   <= fin_val;
        i_fb_den   <= den_val;
        i_fb_data  <= post_video_pkg::pixel_t'(draw_bits(16));
        i_post_rgb <= post_video_pkg::rgb_t'(draw_bits(24));
        if (release_rst)
            rst_n <= 1'b1;
        @(negedge o_post_clk);
        check_outputs();
    endtask

    // wait frames, finish pulse length, frames to observe
    task automatic load_table();
        stim_table[0] = '{0, 1, 3};
        stim_table[1] = '{1, 4, 3};
        stim_table[2] = '{0, 37, 3};
        stim_table[3] = '{2, 100, 4};
        stim_table[4] = '{0, 2, 3};
        stim_table[5] = '{1, 200, 3};
    endtask

    initial
    begin
        int total_cycles;
        rst_n       = 1'b0;
        i_finish    = 1'b0;
        i_fb_den    = 1'b0;
        i_fb_data   = '0;
        i_post_rgb  = '0;
        lfsr_state  = 16'd70;
        exp_rgb     = '0;
        de_run      = 0;
        line_cnt    = 0;
        frames_seen = 0;
        camvs_rises = 0;
        prev_de     = 1'b0;
        prev_vs     = 1'b1;
        prev_camvs  = 1'b0;
        load_table();
        total_cycles = RESET_CYCLES;
        for (int r = 0; r < N_ROWS; r++)
            total_cycles = total_cycles + stim_table[r].pulse_len +
                (stim_table[r].wait_frames + stim_table[r].observe_frames) * FRAME_CYCLES;
        cycle_limit = total_cycles + 2 * FRAME_CYCLES;
        model_reset();
        for (int i = 0; i < RESET_CYCLES; i++)
        begin
            step(1'b0, 1'b0, i == RESET_CYCLES - 1);
            check_reset_outputs();
        end
        for (int r = 0; r < N_ROWS; r++)
        begin
            camvs_rises = 0;
            repeat (stim_table[r].wait_frames * FRAME_CYCLES) step(1'b1, 1'b0, 1'b0);
            repeat (stim_table[r].pulse_len) step(1'b1, 1'b1, 1'b0);
            repeat (stim_table[r].observe_frames * FRAME_CYCLES) step(1'b1, 1'b0, 1'b0);
            assert (camvs_rises == 1) else report_value("o_post_camvs rises", camvs_rises, 1);
            assert (o_post_camvs === 1'b0) else report_value("o_post_camvs", o_post_camvs, 0);
        end
        assert (frames_seen > 0)
        begin
            $display("TESTS PASSED");
            $finish;
        end
        else
            report_plain("no complete frame was seen on o_post_vs");
    end

    always @(posedge o_post_clk)
    begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit)
            report_plain("timeout, the run went past its cycle limit");
    end

endmodule

`default_nettype wire

//--- video_timing/sync_delay_line.sv
`timescale 1ns/100ps
`default_nettype none

`include "post_video_params.svh"

module sync_delay_line
(
    input  wire                         o_post_clk,
    input  wire                         rst_n,
    input  post_video_pkg::video_sync_t i_sync,
    output post_video_pkg::video_sync_t o_early_sync,
    output post_video_pkg::video_sync_t o_late_sync
);

    // stage 0 holds i_sync delayed by one cycle
    post_video_pkg::video_sync_t sync_dly [`POST_TOTAL_DELAY];

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `POST_TOTAL_DELAY; i++)
                sync_dly[i] <= post_video_pkg::SYNC_IDLE;   // blanked until timing arrives
        end
        else
        begin
            sync_dly[0] <= i_sync;
            for (int i = 1; i < `POST_TOTAL_DELAY; i++)
                sync_dly[i] <= sync_dly[i-1];
        end
    end

    // early tap lines up with the frame buffer read pixels
    assign o_early_sync = sync_dly[`POST_IN_DELAY-1];

    // late tap covers the post block latency as well
    assign o_late_sync  = sync_dly[`POST_TOTAL_DELAY-1];

endmodule

`default_nettype wire

//--- video_timing/video_timing_gen.sv
`timescale 1ns/100ps
`default_nettype none

`include "post_video_params.svh"

module video_timing_gen
#(
    parameter int H_ACTIVE = `POST_H_ACTIVE,
    parameter int H_FP     = `POST_H_FP,
    parameter int H_SYNC   = `POST_H_SYNC,
    parameter int H_BP     = `POST_H_BP,
    parameter int V_ACTIVE = `POST_V_ACTIVE,
    parameter int V_FP     = `POST_V_FP,
    parameter int V_SYNC   = `POST_V_SYNC,
    parameter int V_BP     = `POST_V_BP
)
(
    input  wire                         o_post_clk,
    input  wire                         rst_n,
    output post_video_pkg::video_sync_t o_sync
);

    // order within a line or frame is active, front porch, sync, back porch
    localparam int H_TOTAL    = H_ACTIVE + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL    = V_ACTIVE + V_FP + V_SYNC + V_BP;
    localparam int H_SYNC_BEG = H_ACTIVE + H_FP;
    localparam int H_SYNC_END = H_SYNC_BEG + H_SYNC;
    localparam int V_SYNC_BEG = V_ACTIVE + V_FP;
    localparam int V_SYNC_END = V_SYNC_BEG + V_SYNC;

    post_video_pkg::count_t      h_cnt;
    post_video_pkg::count_t      v_cnt;
    logic                        h_last;
    logic                        v_last;
    post_video_pkg::video_sync_t sync_next;

    assign h_last = (h_cnt == post_video_pkg::count_t'(H_TOTAL - 1));
    assign v_last = (v_cnt == post_video_pkg::count_t'(V_TOTAL - 1));

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            h_cnt <= '0;
            v_cnt <= '0;
        end
        else
        begin
            if (h_last)
            begin
                h_cnt <= '0;
                if (v_last)
                    v_cnt <= '0;
                else
                    v_cnt <= v_cnt + 1'b1;
            end
            else
            begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
    end

    // decode from the current position
    always_comb
    begin
        sync_next.hs = !((h_cnt >= post_video_pkg::count_t'(H_SYNC_BEG)) &&
                         (h_cnt <  post_video_pkg::count_t'(H_SYNC_END)));
        sync_next.vs = !((v_cnt >= post_video_pkg::count_t'(V_SYNC_BEG)) &&
                         (v_cnt <  post_video_pkg::count_t'(V_SYNC_END)));
        sync_next.de = (h_cnt < post_video_pkg::count_t'(H_ACTIVE)) &&
                       (v_cnt < post_video_pkg::count_t'(V_ACTIVE));
    end

    always_ff @(posedge o_post_clk or negedge rst_n)
    begin
        if (!rst_n)
            o_sync <= post_video_pkg::SYNC_IDLE;
        else
            o_sync <= sync_next;   // one cycle behind the counters
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
+incdir+testbench
common/post_video_pkg.sv
video_timing/video_timing_gen.sv
video_timing/sync_delay_line.sv
hdl/pixel_stage.sv
hdl/frame_gate_ctrl.sv
hdl/post_video_top.sv
testbench/post_video_tb.sv
